// ==== Makefile ====
SIM = obj_dir/Vtb_fetch_frontend

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): files.f $(shell cat files.f)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_fetch_frontend -f files.f

# Pass only if the simulation prints the pass line
run: $(SIM)
	./$(SIM) | awk '{ print } /^=== PASS ===$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== btb/btb.sv ====
`timescale 1ns/1ps

module btb import frontend_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] i_pc,
    input  btb_upd_t    i_upd,
    output pred_t       o_pred1,
    output pred_t       o_pred2
);

    typedef struct packed {
        logic [BTB_TAG_W-1:0] tag;
        logic [31:0]          target;
        brtype_e              brtype;
    } btb_entry_t;

    btb_entry_t                 entry_q [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0]     valid_q;
    logic [BTB_IDX_W-1:0]       upd_idx;

    // Word bit 2 stays in the tag so both slots of a pair can be told apart
    function automatic logic [BTB_TAG_W-1:0] tag_of(input logic [31:0] pc);
        tag_of = {pc[31:3+BTB_IDX_W], pc[2]};
    endfunction

    function automatic logic [BTB_IDX_W-1:0] idx_of(input logic [31:0] pc);
        idx_of = pc[2+BTB_IDX_W:3];
    endfunction

    // Miss falls through to the next word
    function automatic pred_t lookup(input logic [31:0] pc);
        logic [BTB_IDX_W-1:0] idx;
        pred_t                p;
        idx      = idx_of(pc);
        p.brtype = BR_NONE;
        p.npc    = pc + 32'd4;
        if (valid_q[idx] && (entry_q[idx].tag == tag_of(pc))) begin
            p.brtype = entry_q[idx].brtype;
            p.npc    = entry_q[idx].target;
        end
        return p;
    endfunction

    always_comb begin
        o_pred1 = lookup(i_pc);
        o_pred2 = lookup(i_pc + 32'd4);
    end

    assign upd_idx = idx_of(i_upd.pc);

    ////////////////////////////////////////////////////////////////////////
    // Update from IF2, a BR_NONE write clears the entry
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (i_upd.valid) begin
            valid_q[upd_idx] <= (i_upd.brtype != BR_NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (i_upd.valid) begin
            entry_q[upd_idx].tag    <= tag_of(i_upd.pc);
            entry_q[upd_idx].target <= i_upd.target;
            entry_q[upd_idx].brtype <= i_upd.brtype;
        end
    end

endmodule

// ==== common/frontend_pkg.sv ====
package frontend_pkg;

    //////////////////////////////////////////////////////////////////////
    // Constants
    //////////////////////////////////////////////////////////////////////

    // First fetch address out of reset
    localparam logic [31:0] RESET_PC = 32'h1c00_0000;

    // BTB geometry, index taken from PC[6:3]
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_W   = 32 - 2 - BTB_IDX_W;

    // Exception codes, bit 7 flags a live exception
    localparam logic [7:0] ECODE_EXC  = 8'h80;
    localparam logic [7:0] ECODE_ADEF = 8'h08;

    //////////////////////////////////////////////////////////////////////
    // Enums
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_B    = 2'd1,
        BR_BL   = 2'd2
    } brtype_e;

    // Major opcode, instruction bits 31..26
    typedef enum logic [5:0] {
        OP_B  = 6'h14,
        OP_BL = 6'h15
    } op_e;

    //////////////////////////////////////////////////////////////////////
    // Structs
    //////////////////////////////////////////////////////////////////////

    // Per-slot prediction, 34 bits
    typedef struct packed {
        brtype_e     brtype;
        logic [31:0] npc;
    } pred_t;

    // IF1 output toward the IF1/IF2 register
    typedef struct packed {
        logic [31:0] pc1;
        logic [31:0] pc2;
        pred_t       pred1;
        pred_t       pred2;
        logic [7:0]  ecode;
    } if_pair_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] target;
        brtype_e     brtype;
    } btb_upd_t;

    // Bundle handed to decode
    typedef struct packed {
        logic [31:0] pc1;
        logic [31:0] pc2;
        logic [31:0] inst1;
        logic [31:0] inst2;
        logic [1:0]  slot_valid;
        pred_t       pred1;
        pred_t       pred2;
        logic [7:0]  ecode;
    } fetch_bundle_t;

endpackage

// ==== files.f ====
common/frontend_pkg.sv
btb/btb.sv
rtl/pc_gen.sv
rtl/if1_if2.sv
rtl/predecoder.sv
rtl/fetch_out_reg.sv
rtl/fetch_frontend.sv
sim/tb_fetch_frontend.sv

// ==== rtl/fetch_frontend.sv ====
`timescale 1ns/1ps

module fetch_frontend import frontend_pkg::*; (
    input  logic          clk,
    input  logic          rstn,

    // Back-end redirect
    input  redirect_t     i_redirect,

    // Instruction memory
    output logic [31:0]   o_imem_addr,
    output logic          o_imem_req,
    input  logic [63:0]   i_imem_rdata,
    input  logic          i_imem_stall,

    // Toward decode
    output fetch_bundle_t o_fetch,
    output logic          o_fetch_valid,
    input  logic          i_fetch_ready
);

    pred_t         btb_pred1;
    pred_t         btb_pred2;
    if_pair_t      if1_pair;
    if_pair_t      if2_pair;
    logic [1:0]    if2_valid;
    logic          if2_adef;
    logic          pair_valid;
    redirect_t     correct;
    btb_upd_t      btb_upd;
    fetch_bundle_t bundle;
    logic          bundle_valid;
    logic          out_ready;
    logic          stall;

    ////////////////////////////////////////////////////////////////////////
    // Stall and flush
    ////////////////////////////////////////////////////////////////////////

    // Memory stall or full output buffer
    assign stall = i_imem_stall | ~out_ready;

    // A predecoder correction drops the IF1 pair inside pc_gen,
    // the IF1/IF2 register itself flushes on back-end redirects
    assign pair_valid = o_imem_req | if1_pair.ecode[7];

    pc_gen u_pc_gen (
        .clk         (clk),
        .rstn        (rstn),
        .i_redirect  (i_redirect),
        .i_correct   (correct),
        .i_stall     (stall),
        .i_btb_pred1 (btb_pred1),
        .i_btb_pred2 (btb_pred2),
        .o_pc        (o_imem_addr),
        .o_req       (o_imem_req),
        .o_pair      (if1_pair)
    );

    btb u_btb (
        .clk     (clk),
        .rstn    (rstn),
        .i_pc    (o_imem_addr),
        .i_upd   (btb_upd),
        .o_pred1 (btb_pred1),
        .o_pred2 (btb_pred2)
    );

    if1_if2 u_if1_if2 (
        .clk         (clk),
        .rstn        (rstn),
        .i_pair      (if1_pair),
        .i_is_valid  (pair_valid),
        .i_flush     (i_redirect.valid),
        .i_stall     (stall),
        .o_pair      (if2_pair),
        .o_is_valid  (if2_valid),
        .o_sign_adef (if2_adef)
    );

    predecoder u_predecoder (
        .i_pair         (if2_pair),
        .i_is_valid     (if2_valid),
        .i_sign_adef    (if2_adef),
        .i_inst         (i_imem_rdata),
        .o_correct      (correct),
        .o_btb_upd      (btb_upd),
        .o_bundle       (bundle),
        .o_bundle_valid (bundle_valid)
    );

    fetch_out_reg u_fetch_out_reg (
        .clk      (clk),
        .rstn     (rstn),
        .i_bundle (bundle),
        .i_valid  (bundle_valid),
        .i_flush  (i_redirect.valid),
        .o_ready  (out_ready),
        .o_bundle (o_fetch),
        .o_valid  (o_fetch_valid),
        .i_ready  (i_fetch_ready)
    );

endmodule

// ==== rtl/fetch_out_reg.sv ====
`timescale 1ns/1ps

module fetch_out_reg import frontend_pkg::*; (
    input  logic          clk,
    input  logic          rstn,
    input  fetch_bundle_t i_bundle,
    input  logic          i_valid,
    input  logic          i_flush,
    output logic          o_ready,
    output fetch_bundle_t o_bundle,
    output logic          o_valid,
    input  logic          i_ready
);

    logic load;

    // Room when empty or draining this cycle
    assign o_ready = ~o_valid | i_ready;
    assign load    = i_valid & o_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;
        end else if (load) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            o_bundle <= i_bundle;
        end
    end

    // Held bundle must not change under back-pressure
    a_hold_stable: assert property (@(posedge clk) disable iff (!rstn)
        (o_valid && !i_ready && !i_flush) |=> (o_valid && $stable(o_bundle)));

endmodule

// ==== rtl/if1_if2.sv ====
`timescale 1ns/1ps

module if1_if2 import frontend_pkg::*; (
    input  logic       clk,
    input  logic       rstn,

    // From IF1
    input  if_pair_t   i_pair,
    input  logic       i_is_valid,

    // Pipeline control
    input  logic       i_flush,
    input  logic       i_stall,

    // Toward IF2
    output if_pair_t   o_pair,
    output logic [1:0] o_is_valid,
    output logic       o_sign_adef
);

    logic [1:0] valid_q;

    ////////////////////////////////////////////////////////////////////////
    // Slot valid bits
    ////////////////////////////////////////////////////////////////////////

    // Flush beats stall
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 2'b00;
        end else if (i_flush) begin
            valid_q <= 2'b00;
        end else if (!i_stall) begin
            valid_q <= {2{i_is_valid}};
        end
    end

    // IF2 sees nothing while held or being flushed
    assign o_is_valid = valid_q & {2{~i_flush}} & {2{~i_stall}};

    ////////////////////////////////////////////////////////////////////////
    // Payload
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_pair <= i_pair;
        end
    end

    // Any live slot carrying an exception code
    assign o_sign_adef = (|valid_q) & o_pair.ecode[7];

    // IF1 never offers a pair in the same cycle as a back-end flush
    a_no_valid_on_flush: assert property (@(posedge clk) disable iff (!rstn)
        i_flush |-> !i_is_valid);

endmodule

// ==== rtl/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen import frontend_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  redirect_t   i_redirect,
    input  redirect_t   i_correct,
    input  logic        i_stall,
    input  pred_t       i_btb_pred1,
    input  pred_t       i_btb_pred2,
    output logic [31:0] o_pc,
    output logic        o_req,
    output if_pair_t    o_pair
);

    typedef enum logic {
        ST_FETCH,
        ST_HALT_ADEF
    } state_e;

    logic [31:0] pc_q;
    logic [31:0] pc_d;
    state_e      state_q;
    state_e      state_d;
    logic        run_q;
    logic        adef_done_q;
    logic        adef_done_d;
    logic        adef_issue;
    logic        pred_taken;

    assign pred_taken = (i_btb_pred1.brtype != BR_NONE);

    // One ADEF pair is sent per misaligned redirect
    assign adef_issue = (state_q == ST_HALT_ADEF) & ~adef_done_q & ~i_redirect.valid;

    // No request while the current PC is being replaced or held
    assign o_req = run_q & (state_q == ST_FETCH) & ~i_redirect.valid
                 & ~i_correct.valid & ~i_stall;

    always_comb begin
        pc_d        = pc_q;
        state_d     = state_q;
        adef_done_d = adef_done_q;
        if (i_redirect.valid) begin
            pc_d        = i_redirect.target;
            state_d     = (i_redirect.target[1:0] == 2'b00) ? ST_FETCH : ST_HALT_ADEF;
            adef_done_d = 1'b0;
        end else if (i_correct.valid) begin
            pc_d = i_correct.target;
        end else if (i_stall || !run_q) begin
            pc_d = pc_q;
        end else if (state_q == ST_FETCH) begin
            pc_d = pred_taken ? i_btb_pred1.npc : pc_q + 32'd8;
        end else begin
            adef_done_d = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_q        <= RESET_PC;
            state_q     <= ST_FETCH;
            run_q       <= 1'b0;
            adef_done_q <= 1'b0;
        end else begin
            pc_q        <= pc_d;
            state_q     <= state_d;
            run_q       <= 1'b1;
            adef_done_q <= adef_done_d;
        end
    end

    assign o_pc         = pc_q;
    assign o_pair.pc1   = pc_q;
    assign o_pair.pc2   = pc_q + 32'd4;
    assign o_pair.pred1 = i_btb_pred1;
    assign o_pair.pred2 = i_btb_pred2;
    assign o_pair.ecode = adef_issue ? (ECODE_EXC | ECODE_ADEF) : 8'h00;

    // Misaligned targets only ever reach the halt state
    a_req_aligned: assert property (@(posedge clk) disable iff (!rstn)
        o_req |-> (o_pc[1:0] == 2'b00));

endmodule

// ==== rtl/predecoder.sv ====
`timescale 1ns/1ps

module predecoder import frontend_pkg::*; (
    input  if_pair_t      i_pair,
    input  logic [1:0]    i_is_valid,
    input  logic          i_sign_adef,
    input  logic [63:0]   i_inst,
    output redirect_t     o_correct,
    output btb_upd_t      o_btb_upd,
    output fetch_bundle_t o_bundle,
    output logic          o_bundle_valid
);

    logic [31:0] inst1;
    logic [31:0] inst2;
    brtype_e     type1;
    brtype_e     type2;
    logic [31:0] tgt1;
    logic [31:0] tgt2;
    logic        v1;
    logic        v2;
    logic        br1;
    logic        br2;
    logic        pred_taken1;
    logic        bad1;
    logic        bad2;
    logic [31:0] pred_npc;
    logic [31:0] real_npc;

    function automatic brtype_e br_type(input logic [31:0] inst);
        op_e op;
        op = op_e'(inst[31:26]);
        case (op)
            OP_B:    br_type = BR_B;
            OP_BL:   br_type = BR_BL;
            default: br_type = BR_NONE;
        endcase
    endfunction

    // offs26 = {inst[9:0], inst[25:10]}, scaled by four
    function automatic logic [31:0] br_target(input logic [31:0] pc, input logic [31:0] inst);
        logic [25:0] offs;
        offs = {inst[9:0], inst[25:10]};
        br_target = pc + {{4{offs[25]}}, offs, 2'b00};
    endfunction

    assign inst1 = i_inst[31:0];
    assign inst2 = i_inst[63:32];
    assign type1 = br_type(inst1);
    assign type2 = br_type(inst2);
    assign tgt1  = br_target(i_pair.pc1, inst1);
    assign tgt2  = br_target(i_pair.pc2, inst2);

    // Direct branches are always taken, so slot 2 dies behind one
    assign v1  = i_is_valid[0] & ~i_sign_adef;
    assign br1 = v1 & (type1 != BR_NONE);
    assign v2  = i_is_valid[1] & ~i_sign_adef & ~br1;
    assign br2 = v2 & (type2 != BR_NONE);

    ////////////////////////////////////////////////////////////////////////
    // Prediction check
    ////////////////////////////////////////////////////////////////////////

    // IF1 only follows slot 1
    assign pred_taken1 = (i_pair.pred1.brtype != BR_NONE);
    assign pred_npc    = pred_taken1 ? i_pair.pred1.npc : i_pair.pc1 + 32'd8;
    assign real_npc    = br1 ? tgt1 : (br2 ? tgt2 : i_pair.pc1 + 32'd8);

    assign bad1 = br1 ? ((i_pair.pred1.brtype != type1) || (i_pair.pred1.npc != tgt1))
                      : (v1 & pred_taken1);
    assign bad2 = br2 & ((i_pair.pred2.brtype != type2) || (i_pair.pred2.npc != tgt2));

    assign o_correct.valid  = v1 & ((real_npc != pred_npc) | bad1);
    assign o_correct.target = real_npc;

    // Slot 1 fix first, slot 2 trained when slot 1 is clean
    always_comb begin
        o_btb_upd.valid  = bad1 | bad2;
        o_btb_upd.pc     = bad1 ? i_pair.pc1 : i_pair.pc2;
        o_btb_upd.target = bad1 ? tgt1 : tgt2;
        o_btb_upd.brtype = bad1 ? type1 : type2;
    end

    ////////////////////////////////////////////////////////////////////////
    // Bundle toward the output register
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        o_bundle.pc1        = i_pair.pc1;
        o_bundle.pc2        = i_pair.pc2;
        o_bundle.inst1      = inst1;
        o_bundle.inst2      = inst2;
        o_bundle.slot_valid = {v2, v1};
        o_bundle.pred1      = i_pair.pred1;
        o_bundle.pred2      = i_pair.pred2;
        o_bundle.ecode      = i_pair.ecode;
    end

    // ADEF pairs still go out, with no live slots
    assign o_bundle_valid = |i_is_valid;

endmodule

// ==== sim/tb_fetch_frontend.sv ====
`timescale 1ns/1ps

module tb_fetch_frontend import frontend_pkg::*; ();

    localparam int MEM_IDX_W          = 7;
    localparam int MEM_WORDS          = 1 << MEM_IDX_W;
    localparam int RUN_LOOP           = 300;
    localparam int RUN_AFTER_REDIRECT = 80;
    localparam int RUN_AFTER_ADEF     = 80;
    localparam int IDLE_CYCLES        = 40;
    localparam int EXPECTED_INSTS     = RUN_LOOP + RUN_AFTER_REDIRECT + RUN_AFTER_ADEF;
    localparam int TIMEOUT_CYCLES     = 40 * EXPECTED_INSTS + IDLE_CYCLES;

    localparam logic [31:0] JUMP_PC   = RESET_PC + 32'h0000_00a0;
    localparam logic [31:0] BAD_PC    = RESET_PC + 32'h0000_0052;
    localparam logic [31:0] RESUME_PC = RESET_PC + 32'h0000_0020;

    typedef enum logic [1:0] {
        MODE_RUN,
        MODE_ADEF,
        MODE_IDLE
    } mode_e;

    logic          clk = 1'b0;
    logic          rstn;
    redirect_t     i_redirect;
    logic [31:0]   o_imem_addr;
    logic          o_imem_req;
    logic [63:0]   i_imem_rdata;
    logic          i_imem_stall;
    fetch_bundle_t o_fetch;
    logic          o_fetch_valid;
    logic          i_fetch_ready;

    logic [31:0]   mem [MEM_WORDS];
    logic [31:0]   rd_addr = RESET_PC;
    logic [31:0]   rd_addr2;
    integer        seed;

    // Reference walk state owned by the compare process
    mode_e         mode = MODE_RUN;
    logic [31:0]   exp_pc = RESET_PC;
    logic [31:0]   adef_pc = '0;
    int            insts = 0;
    int            adef_seen = 0;
    int            checks = 0;
    int            value_errs = 0;
    int            other_errs = 0;
    int            cycle_count = 0;

    always #50 clk = ~clk;

    fetch_frontend u_fetch_frontend (
        .clk           (clk),
        .rstn          (rstn),
        .i_redirect    (i_redirect),
        .o_imem_addr   (o_imem_addr),
        .o_imem_req    (o_imem_req),
        .i_imem_rdata  (i_imem_rdata),
        .i_imem_stall  (i_imem_stall),
        .o_fetch       (o_fetch),
        .o_fetch_valid (o_fetch_valid),
        .i_fetch_ready (i_fetch_ready)
    );

    //////////////////////////////////////////////////////////////////////
    // Instruction memory model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return mem[addr[MEM_IDX_W+1:2]];
    endfunction

    function automatic logic is_branch(input logic [31:0] inst);
        return (inst[31:26] == OP_B) || (inst[31:26] == OP_BL);
    endfunction

    // offs26 split as {inst[9:0], inst[25:10]}
    function automatic logic [31:0] encode_branch(input logic [5:0] op, input int words);
        logic [25:0] offs;
        offs = words[25:0];
        return {op, offs[15:0], offs[25:16]};
    endfunction

    // Accepted request answered in the next cycle and held until the next one
    always @(posedge clk) begin
        if (o_imem_req) begin
            rd_addr <= o_imem_addr;
        end
    end

    assign rd_addr2     = rd_addr + 32'd4;
    assign i_imem_rdata = {mem[rd_addr2[MEM_IDX_W+1:2]], mem[rd_addr[MEM_IDX_W+1:2]]};

    task automatic load_program();
        logic [31:0] w;
        for (int i = 0; i < MEM_WORDS; i++) begin
            w = $random(seed);
            // No accidental direct branches among filler words
            if (is_branch(w)) begin
                w[31] = ~w[31];
            end
            // Short forward branches with targets below the last word
            if (i < MEM_WORDS - 12 && ($random(seed) & 3) == 0) begin
                w = encode_branch(($random(seed) & 1) ? OP_BL : OP_B, 2 + ($random(seed) & 7));
            end
            mem[i] = w;
        end
        // Close the loop back to the reset address
        mem[MEM_WORDS-1] = encode_branch(OP_B, 1 - MEM_WORDS);
    endtask

    task automatic drive_random_inputs();
        forever begin
            @(negedge clk);
            i_imem_stall  = ($random(seed) & 3) == 0;
            i_fetch_ready = ($random(seed) & 3) != 0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference and compare
    //////////////////////////////////////////////////////////////////////

    // Next architectural PC with direct branches always taken
    function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] inst);
        logic [25:0] offs;
        int          disp;
        offs = {inst[9:0], inst[25:10]};
        disp = {{6{offs[25]}}, offs};
        if (is_branch(inst)) begin
            return pc + disp * 4;
        end else begin
            return pc + 32'd4;
        end
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            value_errs++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bundle(input fetch_bundle_t b);
        logic [31:0] w1;
        logic [31:0] w2;
        w1 = mem_word(exp_pc);
        w2 = mem_word(exp_pc + 32'd4);
        assert (mode != MODE_IDLE) else begin
            other_errs++;
            $display("bundle at %h accepted while fetch should idle after ADEF", b.pc1);
        end
        if (mode == MODE_ADEF) begin
            compare_value("o_fetch.pc1", b.pc1, adef_pc);
            compare_value("o_fetch.ecode", {24'd0, b.ecode}, 32'h0000_0088);
            compare_value("o_fetch.slot_valid", {30'd0, b.slot_valid}, 32'd0);
            adef_seen++;
            mode = MODE_IDLE;
        end else if (mode == MODE_RUN) begin
            compare_value("o_fetch.ecode", {24'd0, b.ecode}, 32'd0);
            compare_value("o_fetch.pc1", b.pc1, exp_pc);
            compare_value("o_fetch.pc2", b.pc2, exp_pc + 32'd4);
            compare_value("o_fetch.inst1", b.inst1, w1);
            // Slot 2 is dead behind a taken branch
            if (is_branch(w1)) begin
                compare_value("o_fetch.slot_valid", {30'd0, b.slot_valid}, 32'd1);
                insts += 1;
                exp_pc = next_pc(exp_pc, w1);
            end else begin
                compare_value("o_fetch.slot_valid", {30'd0, b.slot_valid}, 32'd3);
                compare_value("o_fetch.inst2", b.inst2, w2);
                insts += 2;
                exp_pc = next_pc(exp_pc + 32'd4, w2);
            end
        end
    endtask

    always @(posedge clk) begin
        if (rstn) begin
            if (o_fetch_valid && i_fetch_ready) begin
                check_bundle(o_fetch);
            end
            // Redirect applies after any transfer on the same edge
            if (i_redirect.valid) begin
                exp_pc  = i_redirect.target;
                adef_pc = i_redirect.target;
                mode    = (i_redirect.target[1:0] == 2'b00) ? MODE_RUN : MODE_ADEF;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic print_counts(input int extra);
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errs, other_errs + extra);
    endtask

    task automatic wait_insts(input int n);
        int goal;
        goal = insts + n;
        do @(negedge clk); while (insts < goal);
    endtask

    task automatic drive_redirect(input logic [31:0] target);
        i_redirect.valid  = 1'b1;
        i_redirect.target = target;
        @(negedge clk);
        i_redirect = '0;
    endtask

    initial begin
        int end_errs;
        end_errs      = 0;
        seed          = 32'hf847e871;
        rstn          = 1'b0;
        i_redirect    = '0;
        i_imem_stall  = 1'b0;
        i_fetch_ready = 1'b0;
        load_program();
        fork
            drive_random_inputs();
        join_none
        repeat (5) @(posedge clk);
        @(negedge clk);
        assert (!o_fetch_valid && !o_imem_req) else begin
            end_errs++;
            $display("fetch valid or request strobe high during reset");
        end
        rstn = 1'b1;

        // Cold BTB on the first pass and warm on the later ones
        wait_insts(RUN_LOOP);
        drive_redirect(JUMP_PC);
        wait_insts(RUN_AFTER_REDIRECT);

        // Misaligned target gives one ADEF bundle and then silence
        drive_redirect(BAD_PC);
        do @(negedge clk); while (adef_seen == 0);
        repeat (IDLE_CYCLES) @(negedge clk);
        drive_redirect(RESUME_PC);
        wait_insts(RUN_AFTER_ADEF);

        print_counts(end_errs);
        if (value_errs + other_errs + end_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles with %0d of %0d instructions accepted",
                 cycle_count, insts, EXPECTED_INSTS);
        print_counts(1);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
